// ==== hw/rv_isa_pkg.sv ====
// RISC-V base encoding types shared by the decoder and the execute side.
// Only the major opcodes of the integer register and immediate groups are
// listed. Every other opcode is treated as illegal by the decoder.

package rv_isa_pkg;

   // Major opcodes in bits 6:0 of the instruction word.
   typedef enum logic [6:0] {
      OP        = 7'b0110011,  // Register-register ALU operations.
      OP_IMM    = 7'b0010011,  // Register-immediate ALU operations.
      OP_32     = 7'b0111011,  // Word forms of OP, RV64 only.
      OP_IMM_32 = 7'b0011011,  // Word forms of OP-IMM, RV64 only.
      LUI       = 7'b0110111   // Load upper immediate.
   } opcode_e;

   // ALU function in funct3 of the OP and OP-IMM groups.
   // Subtract and arithmetic right shift share the ADD and SRL codes.
   // They are told apart by bit 30 of the instruction word,
   // which the decoder turns into separate flags.
   typedef enum logic [2:0] {
      ADD  = 3'b000,  // Add, or subtract with the sub flag.
      SLL  = 3'b001,  // Shift left logical.
      SLT  = 3'b010,  // Set if less than, signed.
      SLTU = 3'b011,  // Set if less than, unsigned.
      XOR  = 3'b100,
      SRL  = 3'b101,  // Shift right, arithmetic with the ashr flag.
      OR   = 3'b110,
      AND  = 3'b111
   } alu_funct3_e;

   // Architectural register index, x0 to x31.
   typedef logic [4:0] reg_idx_t;

endpackage

// ==== hw/ex_pkg.sv ====
// Types that travel between the decoder and the execute stage.
// The decoded operation carries everything the ALU needs plus the
// register indices. The immediate travels beside it since its width
// follows the XLEN parameter.

package ex_pkg;

   // One decoded integer operation.
   typedef struct packed {
      logic                      sub;       // Subtract instead of add.
      logic                      ashr;      // Arithmetic instead of logical right shift.
      rv_isa_pkg::alu_funct3_e   funct3;    // ALU function.
      logic                      w;         // 32-bit form with sign-extended result.
      logic                      use_imm;   // Second operand is the immediate.
      logic                      zero_rs1;  // First operand is zero.
      rv_isa_pkg::reg_idx_t      rs1;       // First source register.
      rv_isa_pkg::reg_idx_t      rs2;       // Second source register.
      rv_isa_pkg::reg_idx_t      rd;        // Destination register.
   } ex_op_t;

   // Writeback that is pending in the cycle after issue.
   // The execute stage compares both source indices against it to decide
   // on forwarding.
   typedef struct packed {
      logic                      valid;     // A legal instruction was issued last cycle.
      rv_isa_pkg::reg_idx_t      rd;        // Its destination register.
   } wb_idx_t;

endpackage

// ==== hw/ex_decode.sv ====
// Purely combinational decoder for the OP, OP-IMM, OP-32, OP-IMM-32 and
// LUI groups. Anything else, and any reserved funct7 pattern, sets bad.
// At XLEN 32 the word forms are illegal. The op fields are don't-care
// whenever bad is set.
`timescale 1ns/1ps

module ex_decode #(
   parameter int XLEN = 64
) (
   input  logic [31:0]     insn,
   output ex_pkg::ex_op_t  op,
   output logic [XLEN-1:0] imm,
   output logic            bad
);

   logic [6:0] funct7;
   logic       is_shift;  // The funct3 names one of the two shifts.
   logic       w_ok;      // The funct3 exists in the word groups.
   logic       sh_wide;   // Shift amount is six bits wide.

   assign funct7 = insn[31:25];

   always_comb begin
      op        = '0;
      op.funct3 = rv_isa_pkg::alu_funct3_e'(insn[14:12]);
      op.rs1    = insn[19:15];
      op.rs2    = insn[24:20];
      op.rd     = insn[11:7];
      imm       = XLEN'($signed(insn[31:20]));  // I-type by default.
      bad       = 1'b0;
      sh_wide   = 1'b0;
      is_shift  = (op.funct3 == rv_isa_pkg::SLL) || (op.funct3 == rv_isa_pkg::SRL);
      w_ok      = op.funct3 inside {rv_isa_pkg::ADD, rv_isa_pkg::SLL, rv_isa_pkg::SRL};

      case (insn[6:0])
         rv_isa_pkg::OP, rv_isa_pkg::OP_32: begin
            op.w    = insn[3];  // The word group differs only in bit 3.
            op.sub  = funct7[5] && (op.funct3 == rv_isa_pkg::ADD);
            op.ashr = funct7[5] && (op.funct3 == rv_isa_pkg::SRL);
            // Only bit 30 of funct7 may be set, and only for SUB and SRA.
            bad = ((funct7 & 7'b1011111) != '0) || (funct7[5] && !op.sub && !op.ashr);
            if (op.w && ((XLEN < 64) || !w_ok)) begin
               bad = 1'b1;
            end
         end
         rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_IMM_32: begin
            op.w       = insn[3];
            op.use_imm = 1'b1;
            op.rs2     = '0;  // The rs2 field holds immediate bits here.
            if (is_shift) begin
               sh_wide = (XLEN == 64) && !op.w;
               op.ashr = insn[30] && (op.funct3 == rv_isa_pkg::SRL);
               // Bits above the shift amount must be clear, bit 30 aside.
               if (sh_wide) begin
                  bad = (insn[31:26] & 6'b101111) != '0;
               end else begin
                  bad = (funct7 & 7'b1011111) != '0;
               end
               if (insn[30] && !op.ashr) begin
                  bad = 1'b1;  // No arithmetic left shift exists.
               end
               imm = sh_wide ? XLEN'(insn[25:20]) : XLEN'(insn[24:20]);
            end
            if (op.w && ((XLEN < 64) || !w_ok)) begin
               bad = 1'b1;
            end
         end
         rv_isa_pkg::LUI: begin
            // Computed as zero plus the U-type immediate.
            op.funct3   = rv_isa_pkg::ADD;
            op.use_imm  = 1'b1;
            op.zero_rs1 = 1'b1;
            op.rs1      = '0;
            op.rs2      = '0;
            imm         = XLEN'($signed({insn[31:12], 12'b0}));
         end
         default: bad = 1'b1;  // Unsupported major opcode.
      endcase
   end

endmodule

// ==== hw/regfile.sv ====
// Integer register file with two combinational read ports and one write port.
// x0 is not stored. It reads as zero and writes to it are dropped.
// Reset loads every other register xi with the value i.
`timescale 1ns/1ps

module regfile #(
   parameter int XLEN = 64
) (
   input  logic                 clock,
   input  logic                 arst_n,
   input  rv_isa_pkg::reg_idx_t rs1,
   input  rv_isa_pkg::reg_idx_t rs2,
   output logic [XLEN-1:0]      rdata1,
   output logic [XLEN-1:0]      rdata2,
   input  logic                 we,
   input  rv_isa_pkg::reg_idx_t waddr,
   input  logic [XLEN-1:0]      wdata
);

   logic [XLEN-1:0] regs [31:1];  // x1 to x31.

   // The known reset contents let a test predict results from the first issue.
   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= XLEN'(i);
         end
      end else if (we && (waddr != '0)) begin
         regs[waddr] <= wdata;
      end
   end

   // A write shows up on the read ports only after the clock edge.
   assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
   assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hw/alu.sv ====
// Combinational RV64I integer ALU.
// In the word forms only the low 32 bits of both operands count, shift
// amounts use five bits and the 32-bit result is sign-extended. The decoder
// never sets the word flag at XLEN 32.
`timescale 1ns/1ps

module alu #(
   parameter int XLEN = 64
) (
   input  ex_pkg::ex_op_t  op,
   input  logic [XLEN-1:0] a,
   input  logic [XLEN-1:0] b,
   output logic [XLEN-1:0] y
);

   localparam int SHW = $clog2(XLEN);  // Shift amount width of the full forms.

   logic [XLEN-1:0] sum;
   logic [XLEN-1:0] sra;
   logic [31:0]     sra_w;
   logic [XLEN-1:0] full;  // Full-width result.
   logic [31:0]     word;  // 32-bit result of the word forms.
   logic [SHW-1:0]  shamt;
   logic            lt;
   logic            ltu;

   assign shamt = b[SHW-1:0];
   assign sum   = op.sub ? a - b : a + b;  // Low half is also the word sum.
   assign lt    = $signed(a) < $signed(b);
   assign ltu   = a < b;

   // Each arithmetic shift stands alone so that its operand stays signed.
   assign sra   = $signed(a) >>> shamt;
   assign sra_w = $signed(a[31:0]) >>> b[4:0];

   always_comb begin
      case (op.funct3)
         rv_isa_pkg::ADD:  full = sum;
         rv_isa_pkg::SLL:  full = a << shamt;
         rv_isa_pkg::SLT:  full = XLEN'(lt);
         rv_isa_pkg::SLTU: full = XLEN'(ltu);
         rv_isa_pkg::XOR:  full = a ^ b;
         rv_isa_pkg::SRL:  full = op.ashr ? sra : a >> shamt;
         rv_isa_pkg::OR:   full = a | b;
         default:          full = a & b;  // AND is the only code left.
      endcase
   end

   // Only ADD, SLL and SRL exist as word forms.
   always_comb begin
      case (op.funct3)
         rv_isa_pkg::SLL: word = a[31:0] << b[4:0];
         rv_isa_pkg::SRL: word = op.ashr ? sra_w : a[31:0] >> b[4:0];
         default:         word = sum[31:0];
      endcase
   end

   assign y = op.w ? XLEN'($signed(word)) : full;  // Word results are sign-extended.

endmodule

// ==== hw/ex.sv ====
// Execute stage with one register level between operand selection and ALU.
// An instruction issued in cycle T has its result on the outputs in T+1,
// and it is written back at the edge that ends T+1. A source that matches
// the pending destination takes the ALU output directly. Killed issues
// leave no trace in the stage.
`timescale 1ns/1ps

module ex #(
   parameter int XLEN = 64
) (
   input  logic                 clock,
   input  logic                 arst_n,
   input  logic                 issue,
   input  logic                 kill,
   input  ex_pkg::ex_op_t       op,
   input  logic [XLEN-1:0]      imm,
   output rv_isa_pkg::reg_idx_t rs1,
   output rv_isa_pkg::reg_idx_t rs2,
   input  logic [XLEN-1:0]      rdata1,
   input  logic [XLEN-1:0]      rdata2,
   output logic                 we,
   output rv_isa_pkg::reg_idx_t waddr,
   output logic [XLEN-1:0]      wdata,
   output logic                 result_valid,
   output logic [XLEN-1:0]      result,
   output rv_isa_pkg::reg_idx_t result_rd
);

   ex_pkg::wb_idx_t wb;      // Writeback of the instruction now in the ALU.
   ex_pkg::ex_op_t  op_r;    // Operation now in the ALU.
   logic [XLEN-1:0] opa;     // Registered operands.
   logic [XLEN-1:0] opb;
   logic [XLEN-1:0] src_a;   // Operands chosen in the issue cycle.
   logic [XLEN-1:0] src_b;
   logic [XLEN-1:0] alu_y;
   logic            fwd_a;
   logic            fwd_b;
   logic            go;      // A legal instruction enters the stage.

   assign go  = issue && !kill;
   assign rs1 = op.rs1;
   assign rs2 = op.rs2;

   // x0 is never forwarded since the register file already reads it as zero.
   assign fwd_a = wb.valid && (wb.rd != '0) && (op.rs1 == wb.rd);
   assign fwd_b = wb.valid && (wb.rd != '0) && (op.rs2 == wb.rd);

   always_comb begin
      if (op.zero_rs1) begin
         src_a = '0;                  // LUI adds its immediate to zero.
      end else if (fwd_a) begin
         src_a = alu_y;
      end else begin
         src_a = rdata1;
      end
      if (op.use_imm) begin
         src_b = imm;
      end else if (fwd_b) begin
         src_b = alu_y;
      end else begin
         src_b = rdata2;
      end
   end

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         wb <= '0;
      end else begin
         wb.valid <= go;              // High for exactly one cycle per issue.
         if (go) begin
            wb.rd <= op.rd;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (go) begin
         opa  <= src_a;
         opb  <= src_b;
         op_r <= op;
      end
   end

   alu #(
      .XLEN (XLEN)
   ) u_alu (
      .op (op_r),
      .a  (opa),
      .b  (opb),
      .y  (alu_y)
   );

   assign result_valid = wb.valid;
   assign result       = alu_y;
   assign result_rd    = wb.rd;
   assign we           = wb.valid && (wb.rd != '0);  // Writes to x0 are dropped here.
   assign waddr        = wb.rd;
   assign wdata        = alu_y;

endmodule

// ==== hw/ex_top.sv ====
// Integer execute subsystem. One instruction may issue per cycle and
// there is no back-pressure. The result follows the issue by one cycle.
// Illegal encodings pulse illegal in the issue cycle and do nothing else.
`timescale 1ns/1ps

module ex_top #(
   parameter int XLEN = 64
) (
   input  logic                 clock,
   input  logic                 arst_n,
   input  logic                 issue,
   input  logic [31:0]          insn,
   output logic                 result_valid,
   output logic [XLEN-1:0]      result,
   output rv_isa_pkg::reg_idx_t result_rd,
   output logic                 illegal
);

   ex_pkg::ex_op_t       op;
   logic [XLEN-1:0]      imm;
   logic                 bad;
   rv_isa_pkg::reg_idx_t rs1;
   rv_isa_pkg::reg_idx_t rs2;
   rv_isa_pkg::reg_idx_t waddr;
   logic [XLEN-1:0]      rdata1;
   logic [XLEN-1:0]      rdata2;
   logic [XLEN-1:0]      wdata;
   logic                 we;

   ex_decode #(
      .XLEN (XLEN)
   ) u_decode (
      .insn (insn),
      .op   (op),
      .imm  (imm),
      .bad  (bad)
   );

   assign illegal = issue && bad;  // Only meaningful while an instruction is offered.

   regfile #(
      .XLEN (XLEN)
   ) u_regfile (
      .clock  (clock),
      .arst_n (arst_n),
      .rs1    (rs1),
      .rs2    (rs2),
      .rdata1 (rdata1),
      .rdata2 (rdata2),
      .we     (we),
      .waddr  (waddr),
      .wdata  (wdata)
   );

   ex #(
      .XLEN (XLEN)
   ) u_ex (
      .clock        (clock),
      .arst_n       (arst_n),
      .issue        (issue),
      .kill         (bad),   // A bad decode never enters the stage.
      .op           (op),
      .imm          (imm),
      .rs1          (rs1),
      .rs2          (rs2),
      .rdata1       (rdata1),
      .rdata2       (rdata2),
      .we           (we),
      .waddr        (waddr),
      .wdata        (wdata),
      .result_valid (result_valid),
      .result       (result),
      .result_rd    (result_rd)
   );

endmodule

// ==== tb/tb_ex_assert.sv ====
// Concurrent checks bound into the execute stage.
// They are off while arst_n is low.
`timescale 1ns/1ps

module tb_ex_assert #(
   parameter int XLEN = 64
) (
   input logic                 clock,
   input logic                 arst_n,
   input logic                 issue,
   input logic                 kill,
   input ex_pkg::wb_idx_t      wb,
   input rv_isa_pkg::reg_idx_t rs1,
   input logic [XLEN-1:0]      src_a,
   input logic                 result_valid
);

   // A result needs a legal issue one cycle before, so it stays low after reset.
   a_no_spurious_result: assert property (@(posedge clock) disable iff (!arst_n)
      result_valid |-> $past(issue && !kill))
      else $error("result_valid without a legal issue in the cycle before");

   // A pending write to x0 must never reach the next operand through forwarding.
   a_no_x0_forward: assert property (@(posedge clock) disable iff (!arst_n)
      (rs1 == '0) |-> (src_a == '0))
      else $error("x0 was selected as a nonzero first operand");

   a_result_follows_issue: assert property (@(posedge clock) disable iff (!arst_n)
      (issue && !kill) |=> (result_valid && wb.valid))
      else $error("no result one cycle after a legal issue");

endmodule

// ==== tb/tb_ex.sv ====
// Random-instruction testbench for the integer execute subsystem at XLEN 64.
// A model register file predicts every result, destination and illegal pulse.
// Outputs are sampled on the falling edge. Stimulus changes on the rising edge.
`timescale 1ns/1ps

module tb_ex;

   localparam int XLEN    = 64;
   localparam int N_STEPS = 3000;         // Random issue cycles, gaps included.
   localparam int TIMEOUT = 2 * N_STEPS;  // Cycle limit of the whole run.

   logic                 clock;
   logic                 arst_n;
   logic                 issue;
   logic [31:0]          insn;
   logic                 result_valid;
   logic [XLEN-1:0]      result;
   rv_isa_pkg::reg_idx_t result_rd;
   logic                 illegal;

   logic [31:0]          lfsr;
   logic [XLEN-1:0]      mregs [32];      // Model register file.
   logic                 pend_valid;      // A result is due at the next sample.
   logic [XLEN-1:0]      pend_res;
   rv_isa_pkg::reg_idx_t pend_rd;
   logic                 pend_fixed;      // A directed constant is also due.
   logic [XLEN-1:0]      pend_fixed_val;
   int                   cycles;

   ex_top #(.XLEN (XLEN)) UUT (
      .clock        (clock),
      .arst_n       (arst_n),
      .issue        (issue),
      .insn         (insn),
      .result_valid (result_valid),
      .result       (result),
      .result_rd    (result_rd),
      .illegal      (illegal)
   );

   bind ex tb_ex_assert #(.XLEN (XLEN)) u_ex_assert (
      .clock (clock), .arst_n (arst_n), .issue (issue), .kill (kill), .wb (wb),
      .rs1 (rs1), .src_a (src_a), .result_valid (result_valid)
   );

   always #5 clock = ~clock;  // 10 ns period.

   always @(posedge clock) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("Timeout: the run took more than %0d clock cycles.", TIMEOUT);
         $display("Testbench failed");
         $fatal(1, "Cycle limit reached.");
      end
   end

   // Fibonacci LFSR with taps 32, 22, 2 and 1. One step per bit taken.
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // Three picks in four come from x0 to x7, so dependences are frequent.
   function automatic rv_isa_pkg::reg_idx_t pick_reg();
      if (rand_bits(2) != 0) begin
         return 5'(rand_bits(3));
      end
      return 5'(rand_bits(5));
   endfunction

   function automatic logic [XLEN-1:0] sext32(input logic [31:0] v);
      return {{(XLEN-32){v[31]}}, v};
   endfunction

   // ISA reference. Opcode bit 5 tells register forms from immediate forms.
   task automatic predict(input logic [31:0] ins, output logic bad, output logic [XLEN-1:0] res);
      logic [2:0]      f3;
      logic [6:0]      f7;
      logic            alt;   // SUB or SRA, taken from bit 30.
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      logic [XLEN-1:0] sra;
      logic [31:0]     sraw;
      logic [31:0]     w;
      f3   = ins[14:12];
      f7   = ins[31:25];
      a    = mregs[ins[19:15]];
      b    = ins[5] ? mregs[ins[24:20]] : {{(XLEN-12){ins[31]}}, ins[31:20]};
      alt  = ins[30] && ((f3 == 3'd5) || ((f3 == 3'd0) && ins[5]));  // No SUBI exists.
      sra  = $signed(a) >>> b[5:0];
      sraw = $signed(a[31:0]) >>> b[4:0];
      bad  = 1'b0;
      case (f3)
         3'd0:    res = alt ? a - b : a + b;
         3'd1:    res = a << b[5:0];
         3'd2:    res = XLEN'($signed(a) < $signed(b));
         3'd3:    res = XLEN'(a < b);
         3'd4:    res = a ^ b;
         3'd5:    res = alt ? sra : a >> b[5:0];
         3'd6:    res = a | b;
         default: res = a & b;
      endcase
      case (f3)
         3'd1:    w = a[31:0] << b[4:0];
         3'd5:    w = alt ? sraw : a[31:0] >> b[4:0];
         default: w = res[31:0];  // ADDW and SUBW keep the low half of the sum.
      endcase
      case (ins[6:0])
         7'b0110011: bad = !((f7 == 7'h00) || ((f7 == 7'h20) && (f3 inside {3'd0, 3'd5})));
         7'b0010011: begin
            if (f3 == 3'd1) bad = ins[31:26] != 6'h00;
            if (f3 == 3'd5) bad = !(ins[31:26] inside {6'h00, 6'h10});
         end
         7'b0111011: begin
            bad = !(((f7 == 7'h00) && (f3 inside {3'd0, 3'd1, 3'd5}))
                    || ((f7 == 7'h20) && (f3 inside {3'd0, 3'd5})));
            res = sext32(w);
         end
         7'b0011011: begin
            bad = !((f3 == 3'd0) || ((f3 == 3'd1) && (f7 == 7'h00))
                    || ((f3 == 3'd5) && (f7 inside {7'h00, 7'h20})));
            res = sext32(w);
         end
         7'b0110111: res = sext32({ins[31:12], 12'h000});  // LUI.
         default:    bad = 1'b1;
      endcase
   endtask

   // Random fields, weighted toward the legal groups and legal funct7 values.
   function automatic logic [31:0] make_insn();
      logic [2:0]           grp;
      logic [2:0]           f3;
      logic [6:0]           f7;
      logic [11:0]          imm;
      rv_isa_pkg::reg_idx_t rd;
      rv_isa_pkg::reg_idx_t rs1;
      rv_isa_pkg::reg_idx_t rs2;
      grp = 3'(rand_bits(3));
      f3  = 3'(rand_bits(3));
      rd  = pick_reg();
      rs1 = pick_reg();
      rs2 = pick_reg();
      imm = 12'(rand_bits(12));
      case (3'(rand_bits(3)))
         3'd5, 3'd6: f7 = 7'h20;
         3'd7:       f7 = 7'(rand_bits(7));  // Mostly a reserved pattern.
         default:    f7 = 7'h00;
      endcase
      if (f3 inside {3'd1, 3'd5}) begin
         imm[11:5] = (grp == 3'd5) ? f7 : {f7[6:1], imm[5]};  // Six-bit shamt in RV64.
      end
      case (grp)
         3'd0, 3'd1: return {f7, rs2, rs1, f3, rd, 7'b0110011};
         3'd2, 3'd3: return {imm, rs1, f3, rd, 7'b0010011};
         3'd4:       return {f7, rs2, rs1, f3, rd, 7'b0111011};
         3'd5:       return {imm, rs1, f3, rd, 7'b0011011};
         3'd6:       return {imm, rs1, f3, rd, 7'b0110111};
         default:    return rand_bits(32);  // Unknown opcodes, now and then legal.
      endcase
   endfunction

   task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                             input string what);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("Testbench failed");
         $fatal(1, "Wrong value.");
      end
   endtask

   task automatic check_rd(input rv_isa_pkg::reg_idx_t got, input rv_isa_pkg::reg_idx_t exp,
                           input string what);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is x%0d, expected x%0d", $time, what, got, exp);
         $display("Testbench failed");
         $fatal(1, "Wrong register index.");
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         $display("Testbench failed");
         $fatal(1, "Wrong flag.");
      end
   endtask

   // One cycle. The outputs then show the previous instruction's result
   // and the illegal pulse of this one.
   task automatic issue_and_check(input logic [31:0] ins, input logic en, input logic fixed,
                                  input logic [XLEN-1:0] fixed_val);
      logic            bad;
      logic [XLEN-1:0] res;
      @(posedge clock);
      issue <= en;
      insn  <= ins;
      predict(ins, bad, res);
      @(negedge clock);
      check_flag(result_valid, pend_valid, "result_valid");
      if (pend_valid) begin
         check_word(result, pend_res, "result");
         check_rd(result_rd, pend_rd, "result_rd");
      end
      if (pend_fixed) begin
         check_word(result, pend_fixed_val, "directed result");
      end
      check_flag(illegal, en && bad, "illegal");
      pend_valid     = en && !bad;
      pend_res       = res;
      pend_rd        = ins[11:7];
      pend_fixed     = fixed;
      pend_fixed_val = fixed_val;
      if (pend_valid && (pend_rd != '0)) begin
         mregs[pend_rd] = res;  // Illegal and idle cycles leave the model alone.
      end
   endtask

   initial begin
      clock      = 1'b0;
      arst_n     = 1'b0;
      issue      = 1'b0;
      insn       = '0;
      lfsr       = 32'h95ea_a1a4;
      cycles     = 0;
      pend_valid = 1'b0;
      pend_fixed = 1'b0;
      for (int i = 0; i < 32; i++) begin
         mregs[i] = XLEN'(i);
      end
      repeat (5) begin
         @(negedge clock);
         check_flag(result_valid, 1'b0, "result_valid in reset");
      end
      @(posedge clock);
      arst_n <= 1'b1;
      // add x0, x3, x5 gives 8 from the reset values and writes nothing.
      issue_and_check({7'h00, 5'd5, 5'd3, 3'd0, 5'd0, 7'b0110011}, 1'b1, 1'b1, XLEN'(8));
      for (int i = 0; i < 32; i++) begin
         issue_and_check({12'h000, 5'(i), 3'd0, 5'd0, 7'b0010011}, 1'b1, 1'b1, XLEN'(i));
      end
      for (int n = 0; n < N_STEPS; n++) begin
         issue_and_check(make_insn(), rand_bits(2) != 0, 1'b0, '0);  // One cycle in four idle.
      end
      issue_and_check('0, 1'b0, 1'b0, '0);  // Collects the last result.
      $display("Testbench passed");
      $finish;
   end

endmodule

// ==== project.f ====
hw/rv_isa_pkg.sv
hw/ex_pkg.sv
hw/ex_decode.sv
hw/regfile.sv
hw/alu.sv
hw/ex.sv
hw/ex_top.sv
tb/tb_ex_assert.sv
tb/tb_ex.sv

// ==== Makefile ====
SRCS := $(shell cat project.f)

.PHONY: all run lint clean

all: run

run: obj_dir/Vtb_ex
	./obj_dir/Vtb_ex

obj_dir/Vtb_ex: project.f $(SRCS)
	verilator --binary --assert --top-module tb_ex -f project.f

lint:
	verilator --lint-only -Wall --timing --assert --top-module tb_ex -f project.f

clean:
	rm -rf obj_dir
